// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_exec_core
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

// File: sources.f
src/exec_pkg.sv
src/decode_issue.sv
src/alu_unit.sv
src/mul_unit.sv
src/writeback_arbiter.sv
src/exec_core.sv
testbench/tb_exec_core.sv

// File: src/alu_unit.sv
// Single-entry result register, a new op can enter in the cycle it is acked
// SLT is signed, all arithmetic wraps at 32 bits

`timescale 1ns/1ps

module alu_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  exec_pkg::alu_inputs_t  alu_in,
    input  logic                   issue,
    input  logic                   ack,
    output logic                   ready,
    output logic                   done,
    output exec_pkg::unit_result_t result
);
    import exec_pkg::*;

    word_t alu_data;
    logic  lt;

    ////////////////////
    // Datapath
    assign lt = $signed(alu_in.a) < $signed(alu_in.b);

    always_comb begin
        case (alu_in.op)
            ALU_ADD: alu_data = alu_in.a + alu_in.b;
            ALU_SUB: alu_data = alu_in.a - alu_in.b;
            ALU_AND: alu_data = alu_in.a & alu_in.b;
            ALU_OR:  alu_data = alu_in.a | alu_in.b;
            ALU_XOR: alu_data = alu_in.a ^ alu_in.b;
            ALU_SLT: alu_data = {{(XLEN-1){1'b0}}, lt};
            default: alu_data = '0;
        endcase
    end

    ////////////////////
    // Result holding
    // Free when empty or when the arbiter takes the held result this cycle
    assign ready = ~done | ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else if (issue) begin
            done <= 1'b1;
        end else if (ack) begin
            done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            result <= '{id: alu_in.id, rd: alu_in.rd, data: alu_data};
        end
    end

endmodule

// File: src/decode_issue.sv
// Operand values arrive with the operation, so there is no register read here
// Words outside the ALU and MUL/MULH subset are flagged illegal and dropped

`timescale 1ns/1ps

module decode_issue (
    input  logic                  clk,
    input  logic                  rst_n,
    input  exec_pkg::issue_op_t   op,
    input  logic                  op_valid,
    output logic                  op_ready,
    output exec_pkg::alu_inputs_t alu_in,
    output logic                  alu_issue,
    input  logic                  alu_ready,
    output exec_pkg::mul_inputs_t mul_in,
    output logic                  mul_issue,
    input  logic                  mul_ready,
    output logic                  illegal,
    output exec_pkg::id_t         illegal_id
);
    import exec_pkg::*;

    instr_t  instr;
    logic    is_alu;
    logic    is_mul;
    logic    use_imm;
    logic    mul_high;
    alu_op_e alu_op;
    word_t   imm_ext;
    logic    accept;

    assign instr   = op.instr;
    assign imm_ext = {{(XLEN-12){instr.i.imm[11]}}, instr.i.imm};

    ////////////////////
    // Decode
    always_comb begin
        is_alu   = 1'b0;
        is_mul   = 1'b0;
        use_imm  = 1'b0;
        mul_high = 1'b0;
        alu_op   = ALU_ADD;
        case (instr.r.opcode)
            OPC_OP: begin
                if (instr.r.funct7 == F7_BASE) begin
                    is_alu = 1'b1;
                    case (instr.r.funct3)
                        F3_ADD:  alu_op = ALU_ADD;
                        F3_SLT:  alu_op = ALU_SLT;
                        F3_XOR:  alu_op = ALU_XOR;
                        F3_OR:   alu_op = ALU_OR;
                        F3_AND:  alu_op = ALU_AND;
                        default: is_alu = 1'b0;
                    endcase
                end else if (instr.r.funct7 == F7_SUB) begin
                    is_alu = (instr.r.funct3 == F3_ADD);
                    alu_op = ALU_SUB;
                end else if (instr.r.funct7 == F7_MULDIV) begin
                    is_mul   = (instr.r.funct3 == F3_MUL) || (instr.r.funct3 == F3_MULH);
                    mul_high = (instr.r.funct3 == F3_MULH);
                end
            end
            OPC_OP_IMM: begin
                // No SLTI or shifts in this subset
                is_alu  = 1'b1;
                use_imm = 1'b1;
                case (instr.i.funct3)
                    F3_ADD:  alu_op = ALU_ADD;
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                    default: is_alu = 1'b0;
                endcase
            end
            default: ;
        endcase
    end

    ////////////////////
    // Issue handshake
    // Illegal words are always taken so they cannot block the source
    assign op_ready  = is_alu ? alu_ready : (is_mul ? mul_ready : 1'b1);
    assign accept    = op_valid & op_ready;
    assign alu_issue = accept & is_alu;
    assign mul_issue = accept & is_mul;

    assign alu_in = '{
        id: op.id,
        rd: instr.r.rd,
        op: alu_op,
        a:  op.rs1_val,
        b:  use_imm ? imm_ext : op.rs2_val
    };

    assign mul_in = '{
        id:   op.id,
        rd:   instr.r.rd,
        high: mul_high,
        a:    op.rs1_val,
        b:    op.rs2_val
    };

    ////////////////////
    // Illegal word pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            illegal <= 1'b0;
        end else begin
            illegal <= accept & ~is_alu & ~is_mul;
        end
    end

    always_ff @(posedge clk) begin
        if (accept & ~is_alu & ~is_mul) begin
            illegal_id <= op.id;
        end
    end

endmodule

// File: src/exec_core.sv
// Integer back end top, ops arrive with operands already read
// Results leave out of order on one port, tagged by ID

`timescale 1ns/1ps

module exec_core #(
    parameter int MUL_STAGES = exec_pkg::DEFAULT_MUL_STAGES
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  exec_pkg::issue_op_t    op,
    input  logic                   op_valid,
    output logic                   op_ready,
    output logic                   wb_valid,
    output exec_pkg::unit_result_t wb,
    output logic                   illegal,
    output exec_pkg::id_t          illegal_id
);
    import exec_pkg::*;

    ////////////////////
    // Issue side
    alu_inputs_t  alu_in;
    logic         alu_issue;
    logic         alu_ready;
    mul_inputs_t  mul_in;
    logic         mul_issue;
    logic         mul_ready;

    // Unit results
    logic         alu_done;
    logic         alu_ack;
    unit_result_t alu_result;
    logic         mul_done;
    logic         mul_ack;
    unit_result_t mul_result;

    decode_issue u_decode_issue (
        .clk        (clk),
        .rst_n      (rst_n),
        .op         (op),
        .op_valid   (op_valid),
        .op_ready   (op_ready),
        .alu_in     (alu_in),
        .alu_issue  (alu_issue),
        .alu_ready  (alu_ready),
        .mul_in     (mul_in),
        .mul_issue  (mul_issue),
        .mul_ready  (mul_ready),
        .illegal    (illegal),
        .illegal_id (illegal_id)
    );

    ////////////////////
    // Execution units
    alu_unit u_alu_unit (
        .clk    (clk),
        .rst_n  (rst_n),
        .alu_in (alu_in),
        .issue  (alu_issue),
        .ack    (alu_ack),
        .ready  (alu_ready),
        .done   (alu_done),
        .result (alu_result)
    );

    mul_unit #(
        .MUL_STAGES (MUL_STAGES)
    ) u_mul_unit (
        .clk    (clk),
        .rst_n  (rst_n),
        .mul_in (mul_in),
        .issue  (mul_issue),
        .ack    (mul_ack),
        .ready  (mul_ready),
        .done   (mul_done),
        .result (mul_result)
    );

    ////////////////////
    // Writeback
    writeback_arbiter u_writeback_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .alu_done   (alu_done),
        .alu_result (alu_result),
        .mul_done   (mul_done),
        .mul_result (mul_result),
        .alu_ack    (alu_ack),
        .mul_ack    (mul_ack),
        .wb_valid   (wb_valid),
        .wb         (wb)
    );

endmodule

// File: src/exec_pkg.sv
// Shared types and encodings for the integer execution back end
// Only the RV32I ALU subset and the MUL/MULH encodings are covered

package exec_pkg;

    ////////////////////
    // Widths
    localparam int ID_W = 4;
    localparam int XLEN = 32;

    // Default multiplier depth
    localparam int DEFAULT_MUL_STAGES = 3;

    typedef logic [ID_W-1:0] id_t;
    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    ////////////////////
    // Instruction encodings
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_SUB    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    // funct3 values, shared by register and immediate forms
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_MUL  = 3'b000;
    localparam logic [2:0] F3_MULH = 3'b001;

    ////////////////////
    // Instruction word views
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instr_t;

    ////////////////////
    // Operation and unit packets
    typedef struct packed {
        id_t    id;
        instr_t instr;
        word_t  rs1_val;
        word_t  rs2_val;
    } issue_op_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    typedef struct packed {
        id_t       id;
        reg_addr_t rd;
        alu_op_e   op;
        word_t     a;
        word_t     b;
    } alu_inputs_t;

    // high selects the upper half of the product
    typedef struct packed {
        id_t       id;
        reg_addr_t rd;
        logic      high;
        word_t     a;
        word_t     b;
    } mul_inputs_t;

    typedef struct packed {
        id_t       id;
        reg_addr_t rd;
        word_t     data;
    } unit_result_t;

endpackage

// File: src/mul_unit.sv
// Signed 32x32 multiply, MUL_STAGES deep, one op per cycle when not stalled
// An unacked result in the last stage freezes every stage

`timescale 1ns/1ps

module mul_unit #(
    parameter int MUL_STAGES = exec_pkg::DEFAULT_MUL_STAGES
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  exec_pkg::mul_inputs_t  mul_in,
    input  logic                   issue,
    input  logic                   ack,
    output logic                   ready,
    output logic                   done,
    output exec_pkg::unit_result_t result
);
    import exec_pkg::*;

    localparam int LAST = MUL_STAGES - 1;

    // Payload that travels down the pipe with the product
    typedef struct packed {
        id_t                   id;
        reg_addr_t             rd;
        logic                  high;
        logic [2*XLEN-1:0]     prod;
    } mul_stage_t;

    logic signed [2*XLEN-1:0] product;
    mul_stage_t               new_entry;
    mul_stage_t               stage_data [MUL_STAGES];
    logic [MUL_STAGES-1:0]    stage_valid;
    logic                     advance;

    ////////////////////
    // Multiply
    // Extra stages let synthesis retime the multiplier array
    assign product = $signed(mul_in.a) * $signed(mul_in.b);

    assign new_entry = '{
        id:   mul_in.id,
        rd:   mul_in.rd,
        high: mul_in.high,
        prod: product
    };

    ////////////////////
    // Pipeline control
    assign advance = ~(stage_valid[LAST] & ~ack);
    assign ready   = advance;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid <= '0;
        end else if (advance) begin
            stage_valid[0] <= issue;
            for (int i = 1; i < MUL_STAGES; i++) begin
                stage_valid[i] <= stage_valid[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            stage_data[0] <= new_entry;
            for (int i = 1; i < MUL_STAGES; i++) begin
                stage_data[i] <= stage_data[i-1];
            end
        end
    end

    ////////////////////
    // Output
    // Held stable by the freeze until acked
    assign done = stage_valid[LAST];

    assign result = '{
        id:   stage_data[LAST].id,
        rd:   stage_data[LAST].rd,
        data: stage_data[LAST].high ? stage_data[LAST].prod[2*XLEN-1:XLEN]
                                    : stage_data[LAST].prod[XLEN-1:0]
    };

endmodule

// File: src/writeback_arbiter.sv
// Fixed priority, the ALU always wins over the multiplier
// One registered result per cycle, no back-pressure on the writeback port

`timescale 1ns/1ps

module writeback_arbiter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   alu_done,
    input  exec_pkg::unit_result_t alu_result,
    input  logic                   mul_done,
    input  exec_pkg::unit_result_t mul_result,
    output logic                   alu_ack,
    output logic                   mul_ack,
    output logic                   wb_valid,
    output exec_pkg::unit_result_t wb
);

    ////////////////////
    // Grant
    // Multiplier only gets the slot when the ALU has nothing waiting
    assign alu_ack = alu_done;
    assign mul_ack = mul_done & ~alu_done;

    ////////////////////
    // Writeback register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= alu_done | mul_done;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_done) begin
            wb <= alu_result;
        end else if (mul_done) begin
            wb <= mul_result;
        end
    end

endmodule

// File: testbench/tb_exec_core.sv
// Random mix of ALU, multiplier and illegal words with MUL_STAGES fixed at 3
// One expected result is kept per outstanding ID, so IDs are never reused in flight

`timescale 1ns/1ps

module tb_exec_core;
    import exec_pkg::*;

    localparam int MUL_STAGES = 3;
    localparam int NUM_OPS    = 200;
    localparam int MUL_BURST  = 8;
    localparam int NUM_IDS    = 1 << ID_W;
    localparam int TIMEOUT    = NUM_OPS * (MUL_STAGES + 6) + 100;

    localparam logic [6:0] OP_R = 7'b0110011;
    localparam logic [6:0] OP_I = 7'b0010011;

    logic         clk;
    logic         rst_n;
    issue_op_t    op;
    logic         op_valid;
    logic         op_ready;
    logic         wb_valid;
    unit_result_t wb;
    logic         illegal;
    id_t          illegal_id;

    integer seed;
    int     cyc;
    int     value_errs;
    int     proto_errs;
    int     wb_count;
    int     ill_count;

    // Reference model state per ID
    logic [NUM_IDS-1:0] pending;
    logic [NUM_IDS-1:0] kind_ill;
    logic [NUM_IDS-1:0] kind_mul;
    word_t              exp_data [NUM_IDS];
    logic [4:0]         exp_rd [NUM_IDS];
    int                 acc_cyc [NUM_IDS];

    // Expected values of the op now on the bus
    word_t      stim_data;
    logic [4:0] stim_rd;
    logic       stim_mul;
    logic       stim_ill;

    logic rst_seen;
    logic ill_expect;
    id_t  ill_expect_id;

    exec_core #(
        .MUL_STAGES (MUL_STAGES)
    ) u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .op         (op),
        .op_valid   (op_valid),
        .op_ready   (op_ready),
        .wb_valid   (wb_valid),
        .wb         (wb),
        .illegal    (illegal),
        .illegal_id (illegal_id)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////
    // Encoding and reference model
    function automatic word_t encode(input int unsigned kind, input logic [4:0] rd,
                                     input logic [4:0] rs1, input logic [4:0] rs2,
                                     input logic [11:0] imm);
        case (kind)
            0:       return {7'b0000000, rs2, rs1, 3'b000, rd, OP_R};
            1:       return {7'b0100000, rs2, rs1, 3'b000, rd, OP_R};
            2:       return {7'b0000000, rs2, rs1, 3'b111, rd, OP_R};
            3:       return {7'b0000000, rs2, rs1, 3'b110, rd, OP_R};
            4:       return {7'b0000000, rs2, rs1, 3'b100, rd, OP_R};
            5:       return {7'b0000000, rs2, rs1, 3'b010, rd, OP_R};
            6:       return {imm, rs1, 3'b000, rd, OP_I};
            7:       return {imm, rs1, 3'b111, rd, OP_I};
            8:       return {imm, rs1, 3'b110, rd, OP_I};
            9:       return {imm, rs1, 3'b100, rd, OP_I};
            10:      return {7'b0000001, rs2, rs1, 3'b000, rd, OP_R};
            11:      return {7'b0000001, rs2, rs1, 3'b001, rd, OP_R};
            default: return '0;
        endcase
    endfunction

    function automatic word_t model_result(input int unsigned kind, input word_t a,
                                           input word_t b, input logic [11:0] imm);
        logic [63:0] prod;
        word_t       immx;
        immx = {{20{imm[11]}}, imm};
        // Sign-extended operands give the signed product in the low 64 bits
        prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        case (kind)
            0:       return a + b;
            1:       return a - b;
            2:       return a & b;
            3:       return a | b;
            4:       return a ^ b;
            5:       return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            6:       return a + immx;
            7:       return a & immx;
            8:       return a | immx;
            9:       return a ^ immx;
            10:      return prod[31:0];
            11:      return prod[63:32];
            default: return '0;
        endcase
    endfunction

    task automatic report_counts(input int lost);
        $display("Errors: %0d value, %0d protocol, %0d lost (%0d writebacks, %0d illegal)",
                 value_errs, proto_errs, lost, wb_count, ill_count);
    endtask

    ////////////////////
    // Model update just after the falling edge so checks see the old state
    always begin
        @(negedge clk);
        #1;
        if (!rst_n) begin
            ill_expect = 1'b0;
        end else begin
            if (wb_valid) begin
                pending[wb.id] = 1'b0;
                wb_count++;
            end
            if (ill_expect) begin
                pending[ill_expect_id] = 1'b0;
                ill_count++;
            end
            ill_expect = 1'b0;
            if (op_valid && op_ready) begin
                pending[op.id]  = 1'b1;
                kind_ill[op.id] = stim_ill;
                kind_mul[op.id] = stim_mul;
                exp_data[op.id] = stim_data;
                exp_rd[op.id]   = stim_rd;
                acc_cyc[op.id]  = cyc;
                if (stim_ill) begin
                    ill_expect    = 1'b1;
                    ill_expect_id = op.id;
                end
            end
        end
        rst_seen = rst_n;
        cyc = cyc + 1;
    end

    ////////////////////
    // Checks
    a_quiet_reset: assert property (@(negedge clk)
        (cyc > 0 && (!rst_n || !rst_seen)) |-> (!wb_valid && !illegal))
        else begin
            proto_errs++;
            $display("Fail %0t: wb_valid or illegal high around reset", $time);
        end

    // The ALU is acked whenever done so only MUL words see back-pressure
    a_op_ready: assert property (@(negedge clk) disable iff (!rst_n)
        (op_valid && !stim_mul) |-> op_ready)
        else begin
            proto_errs++;
            $display("Fail %0t: op_ready low for an ALU or illegal word", $time);
        end

    a_wb_known: assert property (@(negedge clk) disable iff (!rst_n)
        wb_valid |-> (pending[wb.id] && !kind_ill[wb.id]))
        else begin
            proto_errs++;
            $display("Fail %0t: writeback for ID %0d that is not outstanding", $time, wb.id);
        end

    a_wb_value: assert property (@(negedge clk) disable iff (!rst_n)
        (wb_valid && pending[wb.id] && !kind_ill[wb.id])
            |-> (wb.data == exp_data[wb.id] && wb.rd == exp_rd[wb.id]))
        else begin
            value_errs++;
            $display("Fail %0t: ID %0d got rd %0d data %h, expected rd %0d data %h", $time,
                     wb.id, wb.rd, wb.data, exp_rd[wb.id], exp_data[wb.id]);
        end

    a_wb_latency: assert property (@(negedge clk) disable iff (!rst_n)
        (wb_valid && pending[wb.id] && !kind_ill[wb.id])
            |-> (cyc - acc_cyc[wb.id] >= (kind_mul[wb.id] ? MUL_STAGES + 1 : 2)))
        else begin
            proto_errs++;
            $display("Fail %0t: ID %0d written back after only %0d cycles", $time,
                     wb.id, cyc - acc_cyc[wb.id]);
        end

    a_illegal_pulse: assert property (@(negedge clk) disable iff (!rst_n)
        illegal == ill_expect)
        else begin
            proto_errs++;
            $display("Fail %0t: illegal is %b, expected %b", $time, illegal, ill_expect);
        end

    a_illegal_id: assert property (@(negedge clk) disable iff (!rst_n)
        ill_expect |-> (illegal_id == ill_expect_id))
        else begin
            value_errs++;
            $display("Fail %0t: illegal_id %0d, expected %0d", $time, illegal_id, ill_expect_id);
        end

    ////////////////////
    // Stimulus
    task automatic send_op(input int unsigned kind, input logic bad);
        int unsigned rnd;
        int unsigned start;
        int unsigned cand;
        logic        found;
        logic        taken;
        id_t         id;
        word_t       a;
        word_t       b;
        word_t       word;
        logic [11:0] imm;
        logic [4:0]  rd;
        found = 1'b0;
        id = '0;
        // Pick an ID that is not in flight
        while (!found) begin
            start = $random(seed);
            for (int i = 0; i < NUM_IDS; i++) begin
                cand = (start + i) % NUM_IDS;
                if (!found && !pending[cand]) begin
                    found = 1'b1;
                    id = cand[ID_W-1:0];
                end
            end
            if (!found) begin
                @(posedge clk);
                #1;
            end
        end
        a   = $random(seed);
        b   = $random(seed);
        rnd = $random(seed);
        imm = rnd[11:0];
        rd  = rnd[16:12];
        if (bad) begin
            // LUI opcode is outside the supported subset
            word      = {rnd[31:7], 7'b0110111};
            stim_data = '0;
            stim_rd   = '0;
        end else begin
            word      = encode(kind, rd, rnd[21:17], rnd[26:22], imm);
            stim_data = model_result(kind, a, b, imm);
            stim_rd   = rd;
        end
        stim_mul = !bad && (kind >= 10);
        stim_ill = bad;
        op       = {id, word, a, b};
        op_valid = 1'b1;
        taken    = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = op_valid && op_ready;
            @(posedge clk);
            #1;
        end
        op_valid = 1'b0;
    endtask

    initial begin
        wait (cyc >= TIMEOUT);
        $display("Timeout: run still busy after %0d cycles", TIMEOUT);
        report_counts($countones(pending));
        $display("Verification failed");
        $finish;
    end

    initial begin
        int unsigned rnd;
        int          drain;
        int          lost;
        seed       = 32'h7363_7229;
        rst_n      = 1'b0;
        op         = '0;
        op_valid   = 1'b0;
        cyc        = 0;
        value_errs = 0;
        proto_errs = 0;
        wb_count   = 0;
        ill_count  = 0;
        pending    = '0;
        kind_ill   = '0;
        kind_mul   = '0;
        stim_data  = '0;
        stim_rd    = '0;
        stim_mul   = 1'b0;
        stim_ill   = 1'b0;
        rst_seen   = 1'b0;
        ill_expect = 1'b0;
        ill_expect_id = '0;
        lost       = 0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        for (int n = 0; n < NUM_OPS; n++) begin
            rnd = $random(seed);
            if (n < MUL_BURST) begin
                // Back-to-back MUL and MULH fill the pipeline
                send_op(10 + (n % 2), 1'b0);
            end else begin
                if (rnd[3:0] < 3) begin
                    repeat (rnd[5:4] + 1) begin
                        @(posedge clk);
                        #1;
                    end
                end
                send_op(rnd[15:8] % 12, (rnd[31:16] % 20) == 0);
            end
        end
        drain = 0;
        while (pending != '0 && drain < 50) begin
            @(posedge clk);
            drain++;
        end
        repeat (5) @(posedge clk);
        for (int i = 0; i < NUM_IDS; i++) begin
            if (pending[i]) begin
                lost++;
                $display("Result for ID %0d never came back", i);
            end
        end
        report_counts(lost);
        if (value_errs + proto_errs + lost == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
